//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert --timing -j 0
TOP       = processorTb
FILELIST  = processor.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- processor.f
source/mipsPkg.sv
source/ctrlIf.sv
source/controlDecoder.sv
source/alu.sv
source/registerFile.sv
source/fetchUnit.sv
source/dataPath.sv
source/processor.sv
tb/processor_checker.sv
tb/processorTb.sv

//--- source/alu.sv
module alu (
	input  mipsPkg::aluOp_t aluOp,
	input  mipsPkg::word_t  srcA,
	input  mipsPkg::word_t  srcB,
	output mipsPkg::word_t  result,
	output logic            zero
);
	import mipsPkg::*;

	localparam int laneCount = dataWidth / 8;

	logic [4:0] shiftAmount;

	assign shiftAmount = srcA[4:0]; // variable shifts use rs low bits

	always_comb begin
		result = '0;
		case (aluOp)
			aluAdd:  result = srcA + srcB;
			aluSub:  result = srcA - srcB;
			aluAnd:  result = srcA & srcB;
			aluOr:   result = srcA | srcB;
			aluSlt:  result = (srcA < srcB) ? word_t'(1) : '0; // unsigned compare
			aluAdduQb: begin
				for (int lane = 0; lane < laneCount; lane++) begin
					// each lane wraps on its own, no carry between bytes
					result[8*lane +: 8] = srcA[8*lane +: 8] + srcB[8*lane +: 8];
				end
			end
			aluSllv: result = srcB << shiftAmount;
			aluSrlv: result = srcB >> shiftAmount;
			aluSrav: result = word_t'($signed(srcB) >>> shiftAmount); // sign fill
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- source/controlDecoder.sv
module controlDecoder (
	input  mipsPkg::opcode_t opcode,
	input  mipsPkg::funct_t  funct,
	input  mipsPkg::regAddr_t shamt,
	ctrlIf.decoder           ctrl
);
	import mipsPkg::*;

	always_comb begin
		// everything idle unless an opcode below claims it
		ctrl.regWrite = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.regDst   = 1'b0;
		ctrl.aluSrc   = 1'b0;
		ctrl.branch   = 1'b0;
		ctrl.jump     = 1'b0;
		ctrl.jumpReg  = 1'b0;
		ctrl.aluOp    = aluNone;

		case (opcode)
			opJ: ctrl.jump = 1'b1;
			opJal: begin
				ctrl.jump     = 1'b1;
				ctrl.regWrite = 1'b1; // link into ra
			end
			opJr: ctrl.jumpReg = 1'b1;
			opBeq: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp  = aluSub; // equal when difference is zero
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opSpecial2: begin
				if (funct == fnQb && shamt == shamtQbAdd) begin
					ctrl.regWrite = 1'b1;
					ctrl.regDst   = 1'b1;
					ctrl.aluOp    = aluAdduQb;
				end
			end
			opRtype: begin
				case (funct)
					fnAdd:   ctrl.aluOp = aluAdd;
					fnSub:   ctrl.aluOp = aluSub;
					fnAnd:   ctrl.aluOp = aluAnd;
					fnOr:    ctrl.aluOp = aluOr;
					fnSlt:   ctrl.aluOp = aluSlt;
					fnSllv:  ctrl.aluOp = aluSllv;
					fnSrlv:  ctrl.aluOp = aluSrlv;
					fnSrav:  ctrl.aluOp = aluSrav;
					default: ctrl.aluOp = aluNone;
				endcase
				ctrl.regWrite = (ctrl.aluOp != aluNone); // unknown funct is a nop
				ctrl.regDst   = 1'b1;
			end
			default: ; // undecoded opcode, nop
		endcase
	end

endmodule

//--- source/ctrlIf.sv
interface ctrlIf;
	import mipsPkg::*;

	logic   regWrite;
	logic   memToReg;
	logic   memWrite;
	logic   regDst;   // 1 selects rd, 0 selects rt
	logic   aluSrc;   // 1 selects the sign-extended immediate
	logic   branch;
	logic   jump;     // j or jal
	logic   jumpReg;  // jr
	aluOp_t aluOp;

	modport decoder (output regWrite, memToReg, memWrite, regDst, aluSrc,
		branch, jump, jumpReg, aluOp);

	modport datapath (input regWrite, memToReg, memWrite, regDst, aluSrc,
		branch, jump, jumpReg, aluOp);

endinterface

//--- source/dataPath.sv
module dataPath #(
	parameter mipsPkg::word_t resetPc   = '0,
	parameter mipsPkg::word_t stackInit = 32'h0000_4000
) (
	input  logic           clk,
	input  logic           reset,
	input  mipsPkg::word_t instruction,
	input  mipsPkg::word_t memReadData,
	ctrlIf.datapath        ctrl,
	output mipsPkg::word_t pc,
	output mipsPkg::word_t memAddr,
	output mipsPkg::word_t memWriteData
);
	import mipsPkg::*;

	regAddr_t rs, rt, rd;
	regAddr_t writeAddr;
	word_t    signExtImm;
	word_t    readData1, readData2;
	word_t    aluSrcB, aluResult;
	word_t    writeData;
	word_t    pcPlus4;
	logic     aluZero;
	logic     takeBranch;

	assign rs         = instruction[25:21];
	assign rt         = instruction[20:16];
	assign rd         = instruction[15:11];
	assign signExtImm = {{(dataWidth-16){instruction[15]}}, instruction[15:0]};

	// ----------------------------------------------------------------------
	// operand and writeback selection
	// ----------------------------------------------------------------------
	assign aluSrcB    = ctrl.aluSrc ? signExtImm : readData2;
	assign takeBranch = ctrl.branch & aluZero;
	assign writeAddr  = ctrl.jump ? linkReg : (ctrl.regDst ? rd : rt);
	assign writeData  = ctrl.jump ? pcPlus4 : (ctrl.memToReg ? memReadData : aluResult);

	assign memAddr      = aluResult;
	assign memWriteData = readData2;

	registerFile #(.stackInit(stackInit)) u_registerFile (
		.clk(clk), .reset(reset),
		.readAddr1(rs), .readAddr2(rt), .writeAddr(writeAddr),
		.writeEnable(ctrl.regWrite), .writeData(writeData),
		.readData1(readData1), .readData2(readData2)
	);

	alu u_alu (.aluOp(ctrl.aluOp), .srcA(readData1), .srcB(aluSrcB),
		.result(aluResult), .zero(aluZero));

	fetchUnit #(.resetPc(resetPc)) u_fetchUnit (
		.clk(clk), .reset(reset),
		.takeBranch(takeBranch), .jump(ctrl.jump), .jumpReg(ctrl.jumpReg),
		.branchOffset(signExtImm), .jumpIndex(instruction[25:0]),
		.jumpRegTarget(readData1), // jr reads rs
		.pc(pc), .pcPlus4(pcPlus4)
	);

endmodule

//--- source/fetchUnit.sv
module fetchUnit #(
	parameter mipsPkg::word_t resetPc = '0
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           takeBranch,
	input  logic           jump,
	input  logic           jumpReg,
	input  mipsPkg::word_t branchOffset,
	input  logic [25:0]    jumpIndex,
	input  mipsPkg::word_t jumpRegTarget,
	output mipsPkg::word_t pc,
	output mipsPkg::word_t pcPlus4
);
	import mipsPkg::*;

	word_t branchTarget;
	word_t jumpTarget;
	word_t nextPc;

	// ----------------------------------------------------------------------
	// target arithmetic
	// ----------------------------------------------------------------------
	assign pcPlus4      = pc + pcStep;
	assign branchTarget = pcPlus4 + {branchOffset[dataWidth-3:0], 2'b00}; // word offset
	assign jumpTarget   = {pcPlus4[dataWidth-1 -: 4], jumpIndex, 2'b00}; // same 256MB region

	always_comb begin
		if (jumpReg) begin
			nextPc = jumpRegTarget;
		end else if (jump) begin
			nextPc = jumpTarget;
		end else if (takeBranch) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

//--- source/mipsPkg.sv
package mipsPkg;

	// ----------------------------------------------------------------------
	// widths and basic types
	// ----------------------------------------------------------------------
	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;

	typedef logic [dataWidth-1:0]    word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	// ----------------------------------------------------------------------
	// instruction field encodings
	// ----------------------------------------------------------------------
	typedef enum logic [5:0] {
		opRtype    = 6'b000000,
		opJ        = 6'b000010,
		opJal      = 6'b000011,
		opBeq      = 6'b000100,
		opJr       = 6'b000111, // not the standard MIPS slot
		opAddi     = 6'b001000,
		opSpecial2 = 6'b011111, // .qb group
		opLw       = 6'b100011,
		opSw       = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		fnSllv = 6'b000100,
		fnSrlv = 6'b000110,
		fnSrav = 6'b000111,
		fnQb   = 6'b010000, // under opSpecial2 only
		fnAdd  = 6'b100000,
		fnSub  = 6'b100010,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnSlt  = 6'b101010
	} funct_t;

	typedef enum logic [3:0] {
		aluAnd    = 4'b0000,
		aluOr     = 4'b0001,
		aluAdd    = 4'b0010,
		aluSub    = 4'b0110,
		aluSlt    = 4'b0111,
		aluAdduQb = 4'b1000,
		aluSllv   = 4'b1010,
		aluSrlv   = 4'b1011,
		aluSrav   = 4'b1100,
		aluNone   = 4'b1111 // result forced to zero
	} aluOp_t;

	localparam regAddr_t linkReg    = 5'd31; // ra, jal destination
	localparam word_t    pcStep     = 32'd4;
	localparam regAddr_t shamtQbAdd = 5'd0;  // addu.qb, others unsupported

endpackage

//--- source/processor.sv
module processor #(
	parameter mipsPkg::word_t resetPc   = '0,
	parameter mipsPkg::word_t stackInit = 32'h0000_4000
) (
	input  logic           clk,
	input  logic           reset,
	output mipsPkg::word_t pc,
	input  mipsPkg::word_t instruction,
	output logic           memWrite,
	output mipsPkg::word_t memAddr,
	output mipsPkg::word_t memWriteData,
	input  mipsPkg::word_t memReadData
);
	import mipsPkg::*;

	ctrlIf ctrlBus ();

	controlDecoder u_controlDecoder (
		.opcode(opcode_t'(instruction[31:26])),
		.funct(funct_t'(instruction[5:0])),
		.shamt(instruction[10:6]),
		.ctrl(ctrlBus.decoder)
	);

	dataPath #(.resetPc(resetPc), .stackInit(stackInit)) u_dataPath (
		.clk(clk), .reset(reset),
		.instruction(instruction), .memReadData(memReadData),
		.ctrl(ctrlBus.datapath),
		.pc(pc), .memAddr(memAddr), .memWriteData(memWriteData)
	);

	assign memWrite = ctrlBus.memWrite; // straight from decode, no register

endmodule

//--- source/registerFile.sv
module registerFile #(
	parameter mipsPkg::word_t stackInit = 32'h0000_4000
) (
	input  logic              clk,
	input  logic              reset,
	input  mipsPkg::regAddr_t readAddr1,
	input  mipsPkg::regAddr_t readAddr2,
	input  mipsPkg::regAddr_t writeAddr,
	input  logic              writeEnable,
	input  mipsPkg::word_t    writeData,
	output mipsPkg::word_t    readData1,
	output mipsPkg::word_t    readData2
);
	import mipsPkg::*;

	localparam int       regCount = 2 ** regAddrWidth;
	localparam regAddr_t stackReg = 5'd29; // sp

	word_t regs [regCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= (regAddr_t'(i) == stackReg) ? stackInit : '0;
			end
		end else if (writeEnable && writeAddr != '0) begin // r0 stays zero
			regs[writeAddr] <= writeData;
		end
	end

	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

endmodule

//--- tb/processorTb.sv
module processorTb;
	import mipsPkg::*;

	typedef struct {
		word_t instr;
		word_t readData;
		logic  expWe;
		word_t expAddr;
		logic  checkWd;
		word_t expWd;
		word_t expPc;
	} row_t;

	logic  clk;
	logic  reset;
	word_t pc;
	word_t instruction;
	logic  memWrite;
	word_t memAddr;
	word_t memWriteData;
	word_t memReadData;

	row_t rows[$];
	int   errors;
	int   rowErrors;
	int   passedRows;
	int   cycles;
	int   cycleLimit;

	processor u_processor (
		.clk(clk), .reset(reset), .pc(pc), .instruction(instruction),
		.memWrite(memWrite), .memAddr(memAddr), .memWriteData(memWriteData),
		.memReadData(memReadData)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// instruction encoding and table building
	// ----------------------------------------------------------------------
	function automatic word_t iTypeWord(input logic [5:0] op, input regAddr_t rs,
		input regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t rTypeWord(input logic [5:0] op, input regAddr_t rs,
		input regAddr_t rt, input regAddr_t rd, input logic [4:0] shamt,
		input logic [5:0] fn);
		return {op, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t jTypeWord(input logic [5:0] op, input logic [25:0] index);
		return {op, index};
	endfunction

	task automatic addRow(input word_t instr, input word_t readData, input logic we,
		input word_t addr, input logic checkWd, input word_t wd, input word_t nextPc);
		row_t r;
		r.instr    = instr;
		r.readData = readData;
		r.expWe    = we;
		r.expAddr  = addr;
		r.checkWd  = checkWd;
		r.expWd    = wd;
		r.expPc    = nextPc;
		rows.push_back(r);
	endtask

	task automatic buildProgram();
		// memory traffic with r29 at 0x4000
		addRow(iTypeWord(opSw, 29, 29, 16'h0000), 0, 1, 32'h4000, 1, 32'h4000, 32'h04);
		addRow(iTypeWord(opAddi, 0, 1, 16'h0123), 0, 0, 32'h0123, 0, 0, 32'h08); // r1
		addRow(iTypeWord(opLw, 29, 2, 16'hFFF8), 32'h8000_00F0, 0, 32'h3FF8, 0, 0, 32'h0C);
		addRow(iTypeWord(opSw, 29, 1, 16'h0004), 0, 1, 32'h4004, 1, 32'h0123, 32'h10);
		addRow(iTypeWord(opSw, 29, 2, 16'hFFFC), 0, 1, 32'h3FFC, 1, 32'h8000_00F0, 32'h14);
		addRow(iTypeWord(opLw, 0, 3, 16'h0000), 32'h01FF_7F80, 0, 32'h0, 0, 0, 32'h18); // r3
		// R-type group
		addRow(rTypeWord(opRtype, 1, 2, 4, 0, fnAdd), 0, 0, 32'h8000_0213, 1, 32'h8000_00F0,
			32'h1C);
		addRow(rTypeWord(opRtype, 2, 1, 5, 0, fnSub), 0, 0, 32'h7FFF_FFCD, 0, 0, 32'h20);
		addRow(rTypeWord(opRtype, 2, 3, 6, 0, fnAnd), 0, 0, 32'h0000_0080, 0, 0, 32'h24);
		addRow(rTypeWord(opRtype, 1, 3, 7, 0, fnOr), 0, 0, 32'h01FF_7FA3, 0, 0, 32'h28); // r7
		addRow(rTypeWord(opRtype, 1, 2, 8, 0, fnSlt), 0, 0, 32'h1, 0, 0, 32'h2C); // unsigned
		addRow(rTypeWord(opRtype, 2, 1, 9, 0, fnSlt), 0, 0, 32'h0, 0, 0, 32'h30);
		addRow(iTypeWord(opAddi, 0, 10, 16'h0004), 0, 0, 32'h4, 0, 0, 32'h34); // shift amount
		addRow(rTypeWord(opRtype, 10, 1, 11, 0, fnSllv), 0, 0, 32'h0000_1230, 0, 0, 32'h38);
		addRow(rTypeWord(opRtype, 10, 2, 12, 0, fnSrlv), 0, 0, 32'h0800_000F, 0, 0, 32'h3C);
		addRow(rTypeWord(opRtype, 10, 2, 13, 0, fnSrav), 0, 0, 32'hF800_000F, 0, 0, 32'h40);
		addRow(rTypeWord(opSpecial2, 3, 7, 14, 0, fnQb), 0, 0, 32'h02FE_FE23, 1, 32'h01FF_7FA3,
			32'h44); // lanes wrap alone
		// branches
		addRow(iTypeWord(opBeq, 1, 1, 16'h0002), 0, 0, 32'h0, 0, 0, 32'h50);
		addRow(iTypeWord(opBeq, 1, 2, 16'h0005), 0, 0, 32'h8000_0033, 0, 0, 32'h54);
		addRow(iTypeWord(opBeq, 0, 0, 16'hFFFD), 0, 0, 32'h0, 0, 0, 32'h4C); // backward
		// jumps and link
		addRow(jTypeWord(opJ, 26'h20), 0, 0, 32'h0, 0, 0, 32'h80);
		addRow(jTypeWord(opJal, 26'h40), 0, 0, 32'h0, 0, 0, 32'h100); // ra = 0x84
		addRow(iTypeWord(opJr, 31, 0, 16'h0000), 0, 0, 32'h0, 0, 0, 32'h84);
		addRow(iTypeWord(opSw, 29, 31, 16'h0000), 0, 1, 32'h4000, 1, 32'h84, 32'h88);
		// nops and r0
		addRow(iTypeWord(6'h3F, 0, 1, 16'h0055), 0, 0, 32'h0, 0, 0, 32'h8C);
		addRow(rTypeWord(opRtype, 1, 1, 1, 0, 6'h3F), 0, 0, 32'h0, 0, 0, 32'h90);
		addRow(rTypeWord(opSpecial2, 3, 7, 1, 1, fnQb), 0, 0, 32'h0, 0, 0, 32'h94);
		addRow(iTypeWord(opSw, 29, 1, 16'h0008), 0, 1, 32'h4008, 1, 32'h0123, 32'h98);
		addRow(iTypeWord(opAddi, 0, 0, 16'h0077), 0, 0, 32'h77, 0, 0, 32'h9C);
		addRow(iTypeWord(opSw, 29, 0, 16'h000C), 0, 1, 32'h400C, 1, 32'h0, 32'hA0);
	endtask

	task automatic reportMismatch(input string name, input word_t expected, input word_t actual);
		$display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
		rowErrors++;
	endtask

	// ----------------------------------------------------------------------
	// run limit
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("timeout: run exceeded %0d cycles", cycleLimit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		reset       = 1'b1;
		instruction = '0; // nop during reset
		memReadData = '0;
		errors      = 0;
		passedRows  = 0;
		cycles      = 0;
		cycleLimit  = 0;
		buildProgram();
		cycleLimit = 3 + rows.size() + 20;

		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		if (pc !== 32'h0) begin
			$display("ERR t=%0t pc expected %h actual %h", $time, 32'h0, pc);
			errors++;
		end

		foreach (rows[i]) begin
			rowErrors   = 0;
			instruction = rows[i].instr;
			memReadData = rows[i].readData;
			#30; // outputs settled before the edge
			if (memWrite !== rows[i].expWe) begin
				reportMismatch("memWrite", word_t'(rows[i].expWe), word_t'(memWrite));
			end
			if (memAddr !== rows[i].expAddr) begin
				reportMismatch("memAddr", rows[i].expAddr, memAddr);
			end
			if (rows[i].checkWd && memWriteData !== rows[i].expWd) begin
				reportMismatch("memWriteData", rows[i].expWd, memWriteData);
			end
			@(posedge clk);
			#1;
			if (pc !== rows[i].expPc) begin
				reportMismatch("pc", rows[i].expPc, pc);
			end
			$display("row %0d instr %h %s", i, rows[i].instr, (rowErrors == 0) ? "ok" : "bad");
			if (rowErrors == 0) begin
				passedRows++;
			end
			errors += rowErrors;
			#1;
		end

		$display("rows passed %0d of %0d, errors %0d", passedRows, rows.size(), errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- tb/processor_checker.sv
module processorChecker #(
	parameter mipsPkg::word_t resetPc = '0
) (
	input logic           clk,
	input logic           reset,
	input mipsPkg::word_t pc,
	input mipsPkg::word_t instruction,
	input logic           memWrite
);
	import mipsPkg::*;

	// ----------------------------------------------------------------------
	// strobe, alignment and reset properties
	// ----------------------------------------------------------------------
	strobeOnlyForSw: assert property (@(posedge clk)
		memWrite |-> (instruction[31:26] == opSw))
		else $error("memWrite high for opcode %b", instruction[31:26]);

	pcAligned: assert property (@(posedge clk) disable iff (reset)
		pc[1:0] == 2'b00)
		else $error("pc not word aligned %h", pc);

	pcAfterReset: assert property (@(posedge clk)
		reset |=> (pc == resetPc))
		else $error("pc after reset is %h", pc);

endmodule

bind processor processorChecker #(.resetPc(resetPc)) u_processorChecker (
	.clk(clk), .reset(reset), .pc(pc), .instruction(instruction), .memWrite(memWrite)
);
